// ==== rtl/lsu_params.svh ====
// width, RAM base and RAM depth macros, included by every rtl and dv file that sizes against them
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// data and address width
`define LSU_XLEN 64

// byte address of RAM word 0
`define LSU_RAM_BASE 64'h0000_0000_8000_0000

// word index width, 256 words of 8 bytes
`define LSU_RAM_AW 8

`endif

// ==== rtl/lsu_pkg.sv ====
// enum types shared by the load/store unit and its testbench, imported where needed
package lsu_pkg;

  // decoded memory operation
  typedef enum logic [1:0] {
    op_load    = 2'd0,
    op_store   = 2'd1,
    op_illegal = 2'd2  // no memory access, flagged at done
  } mem_op_e;

  // access size, coded as log2 of the byte count
  typedef enum logic [1:0] {
    sz_byte  = 2'd0,
    sz_half  = 2'd1,
    sz_word  = 2'd2,
    sz_dword = 2'd3
  } size_e;

  // execute sequencer
  typedef enum logic [1:0] {
    st_idle   = 2'd0,
    st_first  = 2'd1,  // first (or only) word access
    st_second = 2'd2   // upper word of a split access
  } seq_state_e;

endpackage

// ==== rtl/lsu_decode.sv ====
// combinational RV64 load/store decoder feeding the execute stage of the load/store unit
`timescale 1ns/10ps
`include "lsu_params.svh"

module lsu_decode (
  input  logic [31:0]           instr,
  output lsu_pkg::mem_op_e      op,
  output lsu_pkg::size_e        size,
  output logic                  sign,
  output logic [4:0]            rd,
  output logic [`LSU_XLEN-1:0]  imm
);
  import lsu_pkg::*;

  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;

  logic [6:0] opcode;
  logic [2:0] funct3;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];

  always_comb begin
    op = op_illegal;
    if (opcode == OPC_LOAD) begin
      case (funct3)
        3'b000,                  // lb
        3'b001,                  // lh
        3'b010,                  // lw
        3'b011,                  // ld
        3'b100,                  // lbu
        3'b101,                  // lhu
        3'b110: op = op_load;    // lwu
        default: op = op_illegal;
      endcase
    end else if (opcode == OPC_STORE) begin
      case (funct3)
        3'b000,                  // sb
        3'b001,                  // sh
        3'b010,                  // sw
        3'b011: op = op_store;   // sd
        default: op = op_illegal;
      endcase
    end
  end

  // funct3[1:0] is log2 of the byte count for both loads and stores
  assign size = size_e'(funct3[1:0]);
  assign sign = !funct3[2];  // lbu/lhu/lwu zero extend
  assign rd   = instr[11:7];

  always_comb begin
    if (opcode == OPC_STORE) begin
      // s-type
      imm = {{52{instr[31]}}, instr[31:25], instr[11:7]};
    end else begin
      // i-type
      imm = {{52{instr[31]}}, instr[31:20]};
    end
  end

endmodule

// ==== rtl/lsu_execute.sv ====
// request register and word sequencer; splits a byte access into one or two word RAM cycles
`timescale 1ns/10ps
`include "lsu_params.svh"

module lsu_execute (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     instr_valid,
  input  lsu_pkg::mem_op_e         op,
  input  lsu_pkg::size_e           size,
  input  logic                     sign,
  input  logic [4:0]               rd,
  input  logic [`LSU_XLEN-1:0]     imm,
  input  logic [`LSU_XLEN-1:0]     rs1_val,
  input  logic [`LSU_XLEN-1:0]     rs2_val,
  output logic                     busy,
  output logic                     ram_en,
  output logic                     ram_we,
  output logic [`LSU_RAM_AW-1:0]   ram_addr,
  output logic [`LSU_XLEN-1:0]     ram_wdata,
  output logic [7:0]               ram_wmask,
  output logic                     word_first,
  output logic                     word_last,
  output logic [2:0]               byte_offset,
  output lsu_pkg::size_e           size_q,
  output logic                     sign_q,
  output logic                     is_load,
  output logic                     illegal,
  output logic [4:0]               rd_q
);
  import lsu_pkg::*;

  seq_state_e             state;
  mem_op_e                op_q;
  logic                   accept;
  logic [`LSU_XLEN-1:0]   addr_rel;
  logic [3:0]             nbytes;
  logic                   split_d;
  logic                   split_q;
  logic [`LSU_RAM_AW-1:0] word_q;
  logic [`LSU_XLEN-1:0]   wdata_q;
  logic [7:0]             size_mask;
  logic [127:0]           wdata_wide;
  logic [15:0]            wmask_wide;
  logic                   drain;  // mirrors done in lsu_result

  assign accept   = instr_valid && !busy;
  assign addr_rel = rs1_val + imm - `LSU_RAM_BASE;
  assign nbytes   = 4'd1 << size;
  // crosses a word boundary only if offset + size runs past byte 8
  assign split_d  = ({1'b0, addr_rel[2:0]} + nbytes) > 4'd8;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= st_idle;
      busy       <= 1'b0;
      op_q       <= op_illegal;
      word_first <= 1'b0;
      word_last  <= 1'b0;
      drain      <= 1'b0;
    end else begin
      word_first <= (state == st_first);
      word_last  <= (state == st_first && !split_q) || (state == st_second);
      drain      <= word_last;
      case (state)
        st_idle:   if (accept) state <= st_first;
        st_first:  state <= split_q ? st_second : st_idle;
        st_second: state <= st_idle;
        default:   state <= st_idle;
      endcase
      if (accept) begin
        busy <= 1'b1;
        op_q <= op;
      end else if (drain) begin
        busy <= 1'b0;  // drops at the end of the done cycle
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      word_q      <= addr_rel[`LSU_RAM_AW+2:3];  // wraps modulo RAM size
      byte_offset <= addr_rel[2:0];
      split_q     <= split_d && (op != op_illegal);
      size_q      <= size;
      sign_q      <= sign;
      rd_q        <= rd;
      wdata_q     <= rs2_val;
    end
  end

  always_comb begin
    case (size_q)
      sz_byte: size_mask = 8'h01;
      sz_half: size_mask = 8'h03;
      sz_word: size_mask = 8'h0f;
      default: size_mask = 8'hff;
    endcase
  end

  // store data and lanes placed in a 16-byte window, low half to the first word
  assign wdata_wide = {64'd0, wdata_q} << {byte_offset, 3'b000};
  assign wmask_wide = {8'd0, size_mask} << byte_offset;

  assign ram_en    = (state == st_first && op_q != op_illegal) || (state == st_second);
  assign ram_we    = ram_en && (op_q == op_store);
  assign ram_addr  = (state == st_second) ? word_q + `LSU_RAM_AW'(1) : word_q;
  assign ram_wdata = (state == st_second) ? wdata_wide[127:64] : wdata_wide[63:0];
  assign ram_wmask = (state == st_second) ? wmask_wide[15:8] : wmask_wide[7:0];

  assign is_load = (op_q == op_load);
  assign illegal = (op_q == op_illegal);

endmodule

// ==== rtl/dram_model.sv ====
// synthesizable 64-bit word RAM with byte write enables, read data one cycle after the request
`timescale 1ns/10ps
`include "lsu_params.svh"

module dram_model (
  input  logic                    clk,
  input  logic                    ram_en,
  input  logic                    ram_we,
  input  logic [`LSU_RAM_AW-1:0]  ram_addr,
  input  logic [`LSU_XLEN-1:0]    ram_wdata,
  input  logic [7:0]              ram_wmask,
  output logic [`LSU_XLEN-1:0]    ram_rdata
);

  localparam int DEPTH = 1 << `LSU_RAM_AW;

  logic [`LSU_XLEN-1:0] mem [0:DEPTH-1];

  always_ff @(posedge clk) begin
    if (ram_en) begin
      if (ram_we) begin
        for (int b = 0; b < 8; b++) begin
          if (ram_wmask[b]) begin
            mem[ram_addr][8*b +: 8] <= ram_wdata[8*b +: 8];  // untouched lanes keep old bytes
          end
        end
      end else begin
        ram_rdata <= mem[ram_addr];
      end
    end
  end

endmodule

// ==== rtl/lsu_result.sv ====
// load result path; joins split words, aligns and extends the value, and raises done
`timescale 1ns/10ps
`include "lsu_params.svh"

module lsu_result (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   word_first,
  input  logic                   word_last,
  input  logic [`LSU_XLEN-1:0]   ram_rdata,
  input  logic [2:0]             byte_offset,
  input  lsu_pkg::size_e         size_q,
  input  logic                   sign_q,
  input  logic                   is_load,
  input  logic                   illegal,
  input  logic [4:0]             rd_q,
  output logic                   done,
  output logic [`LSU_XLEN-1:0]   load_data,
  output logic [4:0]             rd,
  output logic                   rd_we,
  output logic                   illegal_o
);
  import lsu_pkg::*;

  logic [`LSU_XLEN-1:0] first_word;
  logic [127:0]         merged;
  logic [127:0]         aligned;
  logic [`LSU_XLEN-1:0] shifted;
  logic [`LSU_XLEN-1:0] value;

  always_ff @(posedge clk) begin
    if (word_first) first_word <= ram_rdata;  // lower word of a split access
  end

  // single access sees both strobes at once, so the live word is the low half
  assign merged  = {ram_rdata, word_first ? ram_rdata : first_word};
  assign aligned = merged >> {byte_offset, 3'b000};
  assign shifted = aligned[63:0];

  always_comb begin
    case (size_q)
      sz_byte: value = {{56{sign_q & shifted[7]}}, shifted[7:0]};
      sz_half: value = {{48{sign_q & shifted[15]}}, shifted[15:0]};
      sz_word: value = {{32{sign_q & shifted[31]}}, shifted[31:0]};
      default: value = shifted;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      done      <= 1'b0;
      load_data <= '0;
      rd        <= '0;
      rd_we     <= 1'b0;
      illegal_o <= 1'b0;
    end else begin
      done <= word_last;
      if (word_last) begin
        load_data <= is_load ? value : '0;
        rd        <= rd_q;
        rd_we     <= is_load && (rd_q != 5'd0);  // x0 never written
        illegal_o <= illegal;
      end
    end
  end

endmodule

// ==== rtl/lsu_top.sv ====
// load/store unit top; one instruction in flight, accepted on instr_valid while not busy
`timescale 1ns/10ps
`include "lsu_params.svh"

module lsu_top (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  instr_valid,
  input  logic [31:0]           instr,
  input  logic [`LSU_XLEN-1:0]  rs1_val,
  input  logic [`LSU_XLEN-1:0]  rs2_val,
  output logic                  busy,
  output logic                  done,
  output logic                  illegal,
  output logic [`LSU_XLEN-1:0]  load_data,
  output logic [4:0]            rd,
  output logic                  rd_we
);
  import lsu_pkg::*;

  mem_op_e                dec_op;
  size_e                  dec_size;
  logic                   dec_sign;
  logic [4:0]             dec_rd;
  logic [`LSU_XLEN-1:0]   dec_imm;

  logic                   ram_en;
  logic                   ram_we;
  logic [`LSU_RAM_AW-1:0] ram_addr;
  logic [`LSU_XLEN-1:0]   ram_wdata;
  logic [7:0]             ram_wmask;
  logic [`LSU_XLEN-1:0]   ram_rdata;

  logic                   word_first;
  logic                   word_last;
  logic [2:0]             byte_offset;
  size_e                  size_q;
  logic                   sign_q;
  logic                   is_load;
  logic                   exec_illegal;
  logic [4:0]             rd_q;

  lsu_decode i_lsu_decode (
    .instr (instr),
    .op    (dec_op),
    .size  (dec_size),
    .sign  (dec_sign),
    .rd    (dec_rd),
    .imm   (dec_imm)
  );

  lsu_execute i_lsu_execute (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .op          (dec_op),
    .size        (dec_size),
    .sign        (dec_sign),
    .rd          (dec_rd),
    .imm         (dec_imm),
    .rs1_val     (rs1_val),
    .rs2_val     (rs2_val),
    .busy        (busy),
    .ram_en      (ram_en),
    .ram_we      (ram_we),
    .ram_addr    (ram_addr),
    .ram_wdata   (ram_wdata),
    .ram_wmask   (ram_wmask),
    .word_first  (word_first),
    .word_last   (word_last),
    .byte_offset (byte_offset),
    .size_q      (size_q),
    .sign_q      (sign_q),
    .is_load     (is_load),
    .illegal     (exec_illegal),
    .rd_q        (rd_q)
  );

  dram_model i_dram_model (
    .clk       (clk),
    .ram_en    (ram_en),
    .ram_we    (ram_we),
    .ram_addr  (ram_addr),
    .ram_wdata (ram_wdata),
    .ram_wmask (ram_wmask),
    .ram_rdata (ram_rdata)
  );

  lsu_result i_lsu_result (
    .clk         (clk),
    .arst_n      (arst_n),
    .word_first  (word_first),
    .word_last   (word_last),
    .ram_rdata   (ram_rdata),
    .byte_offset (byte_offset),
    .size_q      (size_q),
    .sign_q      (sign_q),
    .is_load     (is_load),
    .illegal     (exec_illegal),
    .rd_q        (rd_q),
    .done        (done),
    .load_data   (load_data),
    .rd          (rd),
    .rd_we       (rd_we),
    .illegal_o   (illegal)
  );

endmodule

// ==== dv/lsu_properties.sv ====
// timing and protocol assertions for the load/store unit, attached to lsu_top by bind
`timescale 1ns/10ps
`include "lsu_params.svh"

module lsu_properties (
  input logic                  clk,
  input logic                  arst_n,
  input logic                  instr_valid,
  input logic [`LSU_XLEN-1:0]  rs1_val,
  input lsu_pkg::mem_op_e      dec_op,
  input lsu_pkg::size_e        dec_size,
  input logic [`LSU_XLEN-1:0]  dec_imm,
  input logic                  busy,
  input logic                  done,
  input logic                  rd_we,
  input logic                  illegal,
  input logic [`LSU_XLEN-1:0]  load_data,
  input logic                  ram_en
);
  import lsu_pkg::*;

  int unsigned fail_count = 0;  // read by the testbench at the end

  logic                 accept;
  logic [`LSU_XLEN-1:0] eff_addr;
  logic                 split;

  assign accept   = instr_valid && !busy;
  assign eff_addr = rs1_val + dec_imm;
  // bytes run past the end of the 8-byte word
  assign split    = (dec_op != op_illegal) &&
                    (({1'b0, eff_addr[2:0]} + (4'd1 << dec_size)) > 4'd8);

  assert property (@(posedge clk) disable iff (!arst_n)
    accept && !split |-> ##1 !done ##1 !done ##1 done)
    else begin
      fail_count++;
      $error("done missing two edges after a single access");
    end

  assert property (@(posedge clk) disable iff (!arst_n)
    accept && split |-> ##1 !done ##1 !done ##1 !done ##1 done)
    else begin
      fail_count++;
      $error("done missing three edges after a split access");
    end

  assert property (@(posedge clk) disable iff (!arst_n) done |=> !done)
    else begin
      fail_count++;
      $error("done longer than one cycle");
    end

  assert property (@(posedge clk) disable iff (!arst_n) accept |=> busy)
    else begin
      fail_count++;
      $error("busy not raised on accept");
    end

  assert property (@(posedge clk) disable iff (!arst_n) done |-> busy)
    else begin
      fail_count++;
      $error("busy low during done");
    end

  assert property (@(posedge clk) disable iff (!arst_n) $fell(busy) |-> $past(done))
    else begin
      fail_count++;
      $error("busy fell without a done cycle");
    end

  // outputs held clear while in reset
  assert property (@(posedge clk)
    !arst_n |-> !busy && !done && !rd_we && !illegal && !ram_en && load_data == '0)
    else begin
      fail_count++;
      $error("outputs not cleared in reset");
    end

endmodule

bind lsu_top lsu_properties i_lsu_properties (
  .clk         (clk),
  .arst_n      (arst_n),
  .instr_valid (instr_valid),
  .rs1_val     (rs1_val),
  .dec_op      (dec_op),
  .dec_size    (dec_size),
  .dec_imm     (dec_imm),
  .busy        (busy),
  .done        (done),
  .rd_we       (rd_we),
  .illegal     (illegal),
  .load_data   (load_data),
  .ram_en      (ram_en)
);

// ==== dv/lsu_tb.sv ====
// testbench for lsu_top; drives loads and stores against a byte shadow of the RAM
`timescale 1ns/10ps
`include "lsu_params.svh"

module lsu_tb;
  import lsu_pkg::*;

  localparam int          MAX_INSTR      = 400;
  localparam int          TIMEOUT_CYCLES = MAX_INSTR * 20 + 200;
  localparam int          RAM_BYTES      = 8 << `LSU_RAM_AW;
  localparam logic [31:0] SEED           = 32'h18b8_cf2b;

  logic                 clk;
  logic                 arst_n;
  logic                 instr_valid;
  logic [31:0]          instr;
  logic [`LSU_XLEN-1:0] rs1_val;
  logic [`LSU_XLEN-1:0] rs2_val;
  logic                 busy;
  logic                 done;
  logic                 illegal;
  logic [`LSU_XLEN-1:0] load_data;
  logic [4:0]           rd;
  logic                 rd_we;

  logic [7:0]           shadow [0:RAM_BYTES-1];
  logic [`LSU_XLEN-1:0] exp_data;
  logic [4:0]           exp_rd;
  logic                 exp_rd_we;
  logic                 exp_illegal;
  logic                 expect_done;
  int                   data_errors = 0;
  int                   instr_count = 0;
  int                   cycles = 0;

  lsu_top i_lsu_top (.*);

  initial clk = 1'b0;
  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, done never arrived", cycles);
      $display("Errors found");
      $finish;
    end
  end

  // response checks in the done cycle
  assert property (@(negedge clk) disable iff (!arst_n) done |-> load_data == exp_data)
    else begin
      data_errors++;
      $display("Error %0t: load_data is %h, expected %h", $time, load_data, exp_data);
    end
  assert property (@(negedge clk) disable iff (!arst_n) done |-> rd == exp_rd)
    else begin
      data_errors++;
      $display("Error %0t: rd is %0d, expected %0d", $time, rd, exp_rd);
    end
  assert property (@(negedge clk) disable iff (!arst_n) done |-> rd_we == exp_rd_we)
    else begin
      data_errors++;
      $display("Error %0t: rd_we is %b, expected %b", $time, rd_we, exp_rd_we);
    end
  assert property (@(negedge clk) disable iff (!arst_n) done |-> illegal == exp_illegal)
    else begin
      data_errors++;
      $display("Error %0t: illegal is %b, expected %b", $time, illegal, exp_illegal);
    end
  assert property (@(negedge clk) disable iff (!arst_n) done |-> expect_done)
    else begin
      data_errors++;
      $display("done pulse at %0t with no instruction pending", $time);
    end

  function automatic logic [31:0] enc_load(logic [2:0] f3, logic [4:0] dst, logic [11:0] imm);
    return {imm, 5'd1, f3, dst, 7'b0000011};
  endfunction

  function automatic logic [31:0] enc_store(logic [2:0] f3, logic [11:0] imm);
    return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic int size_bytes(logic [2:0] f3);
    size_e sz;
    sz = size_e'(f3[1:0]);
    case (sz)
      sz_byte: return 1;
      sz_half: return 2;
      sz_word: return 4;
      default: return 8;
    endcase
  endfunction

  function automatic logic [63:0] read_shadow(logic [2:0] f3, logic [63:0] rel);
    logic [63:0] v;
    int          n;
    v = '0;
    n = size_bytes(f3);
    for (int i = 0; i < n; i++) v[8*i +: 8] = shadow[(rel + 64'(i)) & 64'(RAM_BYTES - 1)];
    if (!f3[2] && n < 8 && v[8*n-1]) v = v | (~64'd0 << (8 * n));  // sign fill
    return v;
  endfunction

  function automatic logic [11:0] rand_imm();
    return 12'($urandom_range(0, 255)) - 12'd128;
  endfunction

  task automatic run_instr(input logic [31:0] ins, input logic [63:0] rs1,
                           input logic [63:0] rs2, input int ghosts);
    @(negedge clk);
    instr_valid = 1'b1;
    instr       = ins;
    rs1_val     = rs1;
    rs2_val     = rs2;
    expect_done = 1'b1;
    instr_count++;
    repeat (ghosts) begin
      @(negedge clk);
      rs2_val = ~rs2;  // other data for the same store that busy must block
    end
    @(negedge clk);
    instr_valid = 1'b0;
    while (!done) @(negedge clk);
    @(negedge clk);
    expect_done = 1'b0;
  endtask

  task automatic do_load(input logic [2:0] f3, input logic [63:0] rel, input logic [4:0] dst);
    logic [11:0] imm;
    imm         = rand_imm();
    exp_data    = read_shadow(f3, rel);
    exp_rd      = dst;
    exp_rd_we   = (dst != 5'd0);
    exp_illegal = 1'b0;
    run_instr(enc_load(f3, dst, imm), `LSU_RAM_BASE + rel - {{52{imm[11]}}, imm},
              {$urandom, $urandom}, 0);
  endtask

  task automatic do_store(input logic [2:0] f3, input logic [63:0] rel,
                          input logic [63:0] data, input int ghosts);
    logic [11:0] imm;
    imm         = rand_imm();
    exp_data    = '0;
    exp_rd      = imm[4:0];
    exp_rd_we   = 1'b0;
    exp_illegal = 1'b0;
    for (int i = 0; i < size_bytes(f3); i++) begin
      shadow[(rel + 64'(i)) & 64'(RAM_BYTES - 1)] = data[8*i +: 8];
    end
    run_instr(enc_store(f3, imm), `LSU_RAM_BASE + rel - {{52{imm[11]}}, imm}, data, ghosts);
  endtask

  task automatic do_illegal(input logic [31:0] ins);
    exp_data    = '0;
    exp_rd      = ins[11:7];
    exp_rd_we   = 1'b0;
    exp_illegal = 1'b1;
    run_instr(ins, `LSU_RAM_BASE + 64'h100, {$urandom, $urandom}, 0);
  endtask

  initial begin
    logic [2:0] load_f3 [6];
    load_f3 = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101, 3'b110};
    arst_n      = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    rs1_val     = '0;
    rs2_val     = '0;
    expect_done = 1'b0;
    exp_data    = '0;
    exp_rd      = '0;
    exp_rd_we   = 1'b0;
    exp_illegal = 1'b0;
    void'($urandom(SEED));
    repeat (10) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    for (int w = 0; w < RAM_BYTES / 8; w++) do_store(3'b011, 64'(w * 8), {$urandom, $urandom}, 0);

    do_store(3'b011, 64'h100, {$urandom, $urandom}, 0);  // aligned sd then ld
    do_load(3'b011, 64'h100, 5'd10);

    for (int off = 0; off < 8; off++) begin
      do_store(3'b011, 64'h200, {$urandom, $urandom}, 0);
      do_store(3'b011, 64'h208, {$urandom, $urandom}, 0);
      foreach (load_f3[k]) do_load(load_f3[k], 64'h200 + 64'(off), 5'($urandom));
    end

    // word crossings up to a wrap from word 255 to word 0
    do_store(3'b011, 64'h305, {$urandom, $urandom}, 0);
    do_load(3'b011, 64'h305, 5'd3);
    do_store(3'b010, 64'h30e, {$urandom, $urandom}, 0);
    do_load(3'b110, 64'h30e, 5'd4);
    do_load(3'b010, 64'h30e, 5'd5);
    do_store(3'b011, 64'h7fd, {$urandom, $urandom}, 0);
    do_load(3'b011, 64'h7fd, 5'd6);
    do_load(3'b001, 64'h7ff, 5'd7);
    do_load(3'b011, 64'h000, 5'd8);
    do_load(3'b011, 64'h7f8, 5'd9);

    do_store(3'b000, 64'h403, {$urandom, $urandom}, 0);
    do_store(3'b001, 64'h409, {$urandom, $urandom}, 0);
    do_store(3'b010, 64'h414, {$urandom, $urandom}, 0);
    for (int w = 0; w < 4; w++) do_load(3'b011, 64'h400 + 64'(w * 8), 5'd20);

    do_illegal(enc_load(3'b111, 5'd11, 12'h000));
    do_illegal(enc_store(3'b100, 12'h000));
    do_illegal({12'h000, 5'd1, 3'b000, 5'd12, 7'b0010011});  // addi
    do_load(3'b011, 64'h100, 5'd13);
    do_load(3'b011, 64'h108, 5'd14);

    do_store(3'b011, 64'h500, {$urandom, $urandom}, 2);
    do_store(3'b011, 64'h50c, {$urandom, $urandom}, 2);
    do_load(3'b011, 64'h500, 5'd15);
    do_load(3'b011, 64'h50c, 5'd16);

    $display("%0d instructions, %0d data errors, %0d protocol errors", instr_count,
             data_errors, i_lsu_top.i_lsu_properties.fail_count);
    if (data_errors == 0 && i_lsu_top.i_lsu_properties.fail_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+rtl
rtl/lsu_pkg.sv
rtl/lsu_decode.sv
rtl/lsu_execute.sv
rtl/dram_model.sv
rtl/lsu_result.sv
rtl/lsu_top.sv
dv/lsu_properties.sv
dv/lsu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the load/store unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f --top-module lsu_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

out=$(./obj_dir/Vlsu_tb +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "No errors"; then
  exit 0
fi
exit 1
